// File: logic/alu_unit.sv
// Integer ALU
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input wire logic clk,
    input wire logic reset,

    input wire logic in_valid,
    output logic in_ready,
    input wire core_pkg::issue_packet_t in_packet,

    output logic out_valid,
    output core_pkg::result_packet_t out_packet
);

    core_pkg::word_t a;
    core_pkg::word_t b;
    logic [4:0] shamt;
    core_pkg::word_t result;

    // Writeback never stalls
    assign in_ready = 1'b1;

    assign a = in_packet.operand_a;
    assign b = in_packet.operand_b;
    assign shamt = b[4:0];

    always_comb begin
        case (in_packet.alu_op)
            core_pkg::alu_add: result = a + b;
            core_pkg::alu_sub: result = a - b;
            core_pkg::alu_sll: result = a << shamt;
            core_pkg::alu_slt: result = {31'b0, $signed(a) < $signed(b)};
            core_pkg::alu_sltu: result = {31'b0, a < b};
            core_pkg::alu_xor: result = a ^ b;
            core_pkg::alu_srl: result = a >> shamt;
            // Arithmetic shift keeps the sign
            core_pkg::alu_sra: result = $signed(a) >>> shamt;
            core_pkg::alu_or: result = a | b;
            core_pkg::alu_and: result = a & b;
            default: result = b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Result packet registered once per accepted issue
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_packet.pc <= in_packet.pc;
            out_packet.rd <= in_packet.rd;
            out_packet.value <= result;
            out_packet.writes_rd <= in_packet.writes_rd;
            out_packet.illegal <= in_packet.illegal;
        end
    end

endmodule

`default_nettype wire

// File: logic/core_pkg.sv
// Core shared definitions
`default_nettype none

package core_pkg;

    // Data path and register file sizes
    localparam int xlen = 32;
    localparam int reg_count = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [$clog2(reg_count)-1:0] reg_addr_t;

    // First pc after reset
    localparam word_t reset_pc = '0;

    // Major opcodes the core accepts
    localparam logic [6:0] opcode_op = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_lui = 7'b0110111;

    // ALU operations, pass_b serves LUI
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    // Fetch to decode
    typedef struct packed {
        word_t pc;
        word_t instruction;
    } fetch_packet_t;

    // Decode to ALU
    typedef struct packed {
        word_t pc;
        word_t operand_a;
        word_t operand_b;
        alu_op_t alu_op;
        reg_addr_t rd;
        logic writes_rd;
        logic illegal;
    } issue_packet_t;

    // ALU to writeback
    typedef struct packed {
        word_t pc;
        reg_addr_t rd;
        word_t value;
        logic writes_rd;
        logic illegal;
    } result_packet_t;

    // Retire record at the core boundary
    typedef struct packed {
        word_t pc;
        reg_addr_t rd;
        word_t value;
        logic illegal;
    } retire_t;

endpackage

`default_nettype wire

// File: logic/decode_stage.sv
// Decode and issue
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input wire logic clk,
    input wire logic reset,

    input wire logic in_valid,
    output logic in_ready,
    input wire core_pkg::fetch_packet_t in_packet,

    // Register file read ports
    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    input wire core_pkg::word_t rs1_data,
    input wire core_pkg::word_t rs2_data,

    output logic out_valid,
    input wire logic out_ready,
    output core_pkg::issue_packet_t out_packet,

    // Scoreboard clear from writeback
    input wire logic clear_valid,
    input wire core_pkg::reg_addr_t clear_rd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    core_pkg::reg_addr_t rd;
    core_pkg::word_t imm_i;
    core_pkg::word_t imm_u;
    core_pkg::alu_op_t alu_op;
    logic uses_rs1;
    logic uses_rs2;
    logic use_imm_i;
    logic use_imm_u;
    logic writes_rd;
    logic illegal;
    logic hazard;
    logic issue;
    logic [core_pkg::reg_count-1:0] in_use;

    // Instruction fields
    assign opcode = in_packet.instruction[6:0];
    assign rd = in_packet.instruction[11:7];
    assign funct3 = in_packet.instruction[14:12];
    assign rs1_addr = in_packet.instruction[19:15];
    assign rs2_addr = in_packet.instruction[24:20];
    assign funct7 = in_packet.instruction[31:25];

    // I-type sign extended, U-type upper 20 bits
    assign imm_i = {{20{in_packet.instruction[31]}}, in_packet.instruction[31:20]};
    assign imm_u = {in_packet.instruction[31:12], 12'b0};

    always_comb begin
        alu_op = core_pkg::alu_add;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        use_imm_i = 1'b0;
        use_imm_u = 1'b0;
        writes_rd = 1'b1;
        illegal = 1'b0;
        case (opcode)
            core_pkg::opcode_op: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                case (funct3)
                    3'b000: alu_op = funct7[5] ? core_pkg::alu_sub : core_pkg::alu_add;
                    3'b001: alu_op = core_pkg::alu_sll;
                    3'b010: alu_op = core_pkg::alu_slt;
                    3'b011: alu_op = core_pkg::alu_sltu;
                    3'b100: alu_op = core_pkg::alu_xor;
                    3'b101: alu_op = funct7[5] ? core_pkg::alu_sra : core_pkg::alu_srl;
                    3'b110: alu_op = core_pkg::alu_or;
                    default: alu_op = core_pkg::alu_and;
                endcase
                // Only SUB and SRA may carry funct7 bit 5
                if (funct7 == 7'b0100000) begin
                    illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
                end else if (funct7 != 7'b0000000) begin
                    illegal = 1'b1;
                end
            end
            core_pkg::opcode_op_imm: begin
                uses_rs1 = 1'b1;
                use_imm_i = 1'b1;
                case (funct3)
                    3'b000: alu_op = core_pkg::alu_add;
                    3'b001: begin
                        alu_op = core_pkg::alu_sll;
                        illegal = (funct7 != 7'b0000000);
                    end
                    3'b010: alu_op = core_pkg::alu_slt;
                    3'b011: alu_op = core_pkg::alu_sltu;
                    3'b100: alu_op = core_pkg::alu_xor;
                    3'b101: begin
                        alu_op = funct7[5] ? core_pkg::alu_sra : core_pkg::alu_srl;
                        illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                    3'b110: alu_op = core_pkg::alu_or;
                    default: alu_op = core_pkg::alu_and;
                endcase
            end
            core_pkg::opcode_lui: begin
                alu_op = core_pkg::alu_pass_b;
                use_imm_u = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
        // Unknown encodings neither read nor write registers
        if (illegal) begin
            uses_rs1 = 1'b0;
            uses_rs2 = 1'b0;
            writes_rd = 1'b0;
        end
    end

    // Stall while a used source is still in flight
    assign hazard = (uses_rs1 && in_use[rs1_addr]) || (uses_rs2 && in_use[rs2_addr]);
    assign out_valid = in_valid && !hazard;
    assign in_ready = out_ready && !hazard;
    assign issue = in_valid && in_ready;

    always_comb begin
        out_packet.pc = in_packet.pc;
        out_packet.operand_a = rs1_data;
        if (use_imm_u) begin
            out_packet.operand_b = imm_u;
        end else if (use_imm_i) begin
            out_packet.operand_b = imm_i;
        end else begin
            out_packet.operand_b = rs2_data;
        end
        out_packet.alu_op = alu_op;
        out_packet.rd = rd;
        out_packet.writes_rd = writes_rd;
        out_packet.illegal = illegal;
    end

    // Scoreboard, a set in the same cycle wins over the clear
    always_ff @(posedge clk) begin
        if (reset) begin
            in_use <= '0;
        end else begin
            if (clear_valid) begin
                in_use[clear_rd] <= 1'b0;
            end
            if (issue && writes_rd && rd != '0) begin
                in_use[rd] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_stage.sv
// Instruction fetch
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input wire logic clk,
    input wire logic reset,

    // Four-phase instruction port
    output logic imem_req,
    output core_pkg::word_t imem_addr,
    input wire logic imem_ack,
    input wire core_pkg::word_t imem_data,

    // Packet towards decode
    output logic out_valid,
    input wire logic out_ready,
    output core_pkg::fetch_packet_t out_packet
);

    typedef enum logic [1:0] {
        st_request,
        st_hold,
        st_wait_drop
    } state_t;

    state_t state;
    core_pkg::word_t pc;
    core_pkg::word_t instruction;

    // Request held high for the whole request phase
    assign imem_req = (state == st_request);
    assign imem_addr = pc;

    assign out_valid = (state == st_hold);
    assign out_packet.pc = pc;
    assign out_packet.instruction = instruction;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_wait_drop;
            pc <= core_pkg::reset_pc;
        end else begin
            case (state)
                st_request: begin
                    // Ack seen, drop req and offer the packet
                    if (imem_ack) begin
                        state <= st_hold;
                    end
                end
                st_hold: begin
                    if (out_ready) begin
                        pc <= pc + 32'd4;
                        // Next request only once ack is low
                        state <= imem_ack ? st_wait_drop : st_request;
                    end
                end
                default: begin
                    if (!imem_ack) begin
                        state <= st_request;
                    end
                end
            endcase
        end
    end

    // Instruction word captured with the ack
    always_ff @(posedge clk) begin
        if (state == st_request && imem_ack) begin
            instruction <= imem_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/pipe_stage_reg.sv
// Valid/ready pipeline register
`timescale 1ns/1ps
`default_nettype none

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input wire logic clk,
    input wire logic reset,

    input wire logic in_valid,
    output logic in_ready,
    input wire payload_t in_data,

    output logic out_valid,
    input wire logic out_ready,
    output payload_t out_data
);

    logic full;

    // Accept when empty or when the held item leaves this cycle
    assign in_ready = !full || out_ready;
    assign out_valid = full;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    // Payload only, no reset needed
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/register_file.sv
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input wire logic clk,
    input wire logic reset,

    input wire core_pkg::reg_addr_t rs1_addr,
    input wire core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t rs1_data,
    output core_pkg::word_t rs2_data,

    input wire logic write_en,
    input wire core_pkg::reg_addr_t write_addr,
    input wire core_pkg::word_t write_data
);

    core_pkg::word_t regs [core_pkg::reg_count];

    // Asynchronous reads, x0 forced to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (write_en && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/rv32_core.sv
// RV32I integer core
`timescale 1ns/1ps
`default_nettype none

module rv32_core (
    input wire logic clk,
    input wire logic reset,

    output logic imem_req,
    output core_pkg::word_t imem_addr,
    input wire logic imem_ack,
    input wire core_pkg::word_t imem_data,

    output logic retire_valid,
    output core_pkg::retire_t retire
);

    // Fetch to fetch register
    logic fetch_valid;
    logic fetch_ready;
    core_pkg::fetch_packet_t fetch_packet;

    // Fetch register to decode
    logic decode_valid;
    logic decode_ready;
    core_pkg::fetch_packet_t decode_packet;

    // Decode to issue register
    logic issue_valid;
    logic issue_ready;
    core_pkg::issue_packet_t issue_packet;

    // Issue register to ALU
    logic alu_valid;
    logic alu_ready;
    core_pkg::issue_packet_t alu_packet;

    // ALU to writeback
    logic result_valid;
    core_pkg::result_packet_t result_packet;

    // Register file and scoreboard
    core_pkg::reg_addr_t rs1_addr;
    core_pkg::reg_addr_t rs2_addr;
    core_pkg::word_t rs1_data;
    core_pkg::word_t rs2_data;
    logic write_en;
    core_pkg::reg_addr_t write_addr;
    core_pkg::word_t write_data;
    logic clear_valid;
    core_pkg::reg_addr_t clear_rd;

    fetch_stage fetch_block (
        .clk(clk), .reset(reset),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_ack(imem_ack), .imem_data(imem_data),
        .out_valid(fetch_valid), .out_ready(fetch_ready), .out_packet(fetch_packet)
    );

    pipe_stage_reg #(.payload_t(core_pkg::fetch_packet_t)) fetch_pipe (
        .clk(clk), .reset(reset),
        .in_valid(fetch_valid), .in_ready(fetch_ready), .in_data(fetch_packet),
        .out_valid(decode_valid), .out_ready(decode_ready), .out_data(decode_packet)
    );

    decode_stage decode_block (
        .clk(clk), .reset(reset),
        .in_valid(decode_valid), .in_ready(decode_ready), .in_packet(decode_packet),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .out_valid(issue_valid), .out_ready(issue_ready), .out_packet(issue_packet),
        .clear_valid(clear_valid), .clear_rd(clear_rd)
    );

    register_file register_file_block (
        .clk(clk), .reset(reset),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .write_en(write_en), .write_addr(write_addr), .write_data(write_data)
    );

    pipe_stage_reg #(.payload_t(core_pkg::issue_packet_t)) issue_pipe (
        .clk(clk), .reset(reset),
        .in_valid(issue_valid), .in_ready(issue_ready), .in_data(issue_packet),
        .out_valid(alu_valid), .out_ready(alu_ready), .out_data(alu_packet)
    );

    alu_unit alu_unit_block (
        .clk(clk), .reset(reset),
        .in_valid(alu_valid), .in_ready(alu_ready), .in_packet(alu_packet),
        .out_valid(result_valid), .out_packet(result_packet)
    );

    writeback_stage write_back_block (
        .in_valid(result_valid), .in_packet(result_packet),
        .write_en(write_en), .write_addr(write_addr), .write_data(write_data),
        .clear_valid(clear_valid), .clear_rd(clear_rd),
        .retire_valid(retire_valid), .retire(retire)
    );

endmodule

`default_nettype wire

// File: logic/writeback_stage.sv
// Writeback and retire
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input wire logic in_valid,
    input wire core_pkg::result_packet_t in_packet,

    output logic write_en,
    output core_pkg::reg_addr_t write_addr,
    output core_pkg::word_t write_data,

    output logic clear_valid,
    output core_pkg::reg_addr_t clear_rd,

    output logic retire_valid,
    output core_pkg::retire_t retire
);

    // No write for illegal ops or x0
    assign write_en = in_valid && in_packet.writes_rd && !in_packet.illegal
        && (in_packet.rd != '0);
    assign write_addr = in_packet.rd;
    assign write_data = in_packet.value;

    // Scoreboard bit only ever set for the same cases
    assign clear_valid = write_en;
    assign clear_rd = in_packet.rd;

    assign retire_valid = in_valid;
    assign retire.pc = in_packet.pc;
    assign retire.rd = in_packet.rd;
    // Illegal ops report a zero value
    assign retire.value = in_packet.illegal ? '0 : in_packet.value;
    assign retire.illegal = in_packet.illegal;

endmodule

`default_nettype wire

// File: sources.f
+incdir+testbench
logic/core_pkg.sv
logic/pipe_stage_reg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/register_file.sv
logic/alu_unit.sv
logic/writeback_stage.sv
logic/rv32_core.sv
testbench/rv32_core_tb.sv

// File: testbench/rv32_core_tb_checks.svh
// Testbench check helpers
`ifndef rv32_core_tb_checks_svh
`define rv32_core_tb_checks_svh

// Running error count for the whole run
int error_count = 0;

// Random source for the memory ack delays
logic [15:0] lfsr_state = 16'd24;

// Taps 16, 14, 13, 11 give a maximal length sequence
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
endfunction

// One LFSR step per bit taken
task automatic take_random_bits(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        value = (value << 1) | lfsr_state[0];
    end
endtask

task automatic check_retire(input core_pkg::retire_t actual,
        input core_pkg::retire_t expected, input int index);
    if (actual !== expected) begin
        error_count++;
        $display("Fail at %0t: retire %0d got pc %h rd %0d value %h illegal %b", $time,
            index, actual.pc, actual.rd, actual.value, actual.illegal);
        $display("    expected pc %h rd %0d value %h illegal %b",
            expected.pc, expected.rd, expected.value, expected.illegal);
    end
endtask

task automatic check_count(input int actual, input int expected);
    if (actual != expected) begin
        error_count++;
        $display("Fail at %0t: %0d instructions retired, expected %0d", $time,
            actual, expected);
    end
endtask

// Counts for the end of the run
task automatic report_counts(input int retired_count, input int expected_count);
    $display("Errors: %0d, retired %0d of %0d", error_count, retired_count, expected_count);
endtask

`endif

// File: testbench/rv32_core_tb.sv
// RV32I core testbench
`timescale 1ns/1ps
`default_nettype none

module rv32_core_tb;

    localparam int prog_len = 32;

    // One program word and the retire record it should produce
    typedef struct packed {
        core_pkg::word_t instruction;
        core_pkg::retire_t expected;
    } program_entry_t;

    logic clk;
    logic reset;
    logic imem_req;
    core_pkg::word_t imem_addr;
    logic imem_ack;
    core_pkg::word_t imem_data;
    logic retire_valid;
    core_pkg::retire_t retire;

    program_entry_t program_table [prog_len];
    int entry_count = 0;
    int retired = 0;

    `include "rv32_core_tb_checks.svh"

    rv32_core dut (
        .clk(clk),
        .reset(reset),
        .imem_req(imem_req),
        .imem_addr(imem_addr),
        .imem_ack(imem_ack),
        .imem_data(imem_data),
        .retire_valid(retire_valid),
        .retire(retire)
    );

    // Instruction encoders
    function automatic core_pkg::word_t encode_op_imm(input logic [2:0] funct3,
            input core_pkg::reg_addr_t rd, input core_pkg::reg_addr_t rs1,
            input logic [11:0] imm);
        return {imm, rs1, funct3, rd, core_pkg::opcode_op_imm};
    endfunction

    function automatic core_pkg::word_t encode_op(input logic [6:0] funct7,
            input logic [2:0] funct3, input core_pkg::reg_addr_t rd,
            input core_pkg::reg_addr_t rs1, input core_pkg::reg_addr_t rs2);
        return {funct7, rs2, rs1, funct3, rd, core_pkg::opcode_op};
    endfunction

    function automatic core_pkg::word_t encode_lui(input core_pkg::reg_addr_t rd,
            input logic [19:0] imm);
        return {imm, rd, core_pkg::opcode_lui};
    endfunction

    // Next table entry, pc follows from its position
    task automatic add_entry(input core_pkg::word_t instruction, input core_pkg::reg_addr_t rd,
            input core_pkg::word_t value, input logic illegal);
        core_pkg::retire_t expected;
        expected.pc = entry_count * 4;
        expected.rd = rd;
        expected.value = value;
        expected.illegal = illegal;
        program_table[entry_count].instruction = instruction;
        program_table[entry_count].expected = expected;
        entry_count++;
    endtask

    task automatic build_program();
        // Immediate ops and LUI on known register contents
        add_entry(encode_op_imm(3'b000, 1, 0, 12'h005), 1, 32'h00000005, 1'b0);
        add_entry(encode_op_imm(3'b000, 2, 0, 12'hFFD), 2, 32'hFFFFFFFD, 1'b0);
        add_entry(encode_lui(3, 20'h12345), 3, 32'h12345000, 1'b0);
        add_entry(encode_op_imm(3'b110, 4, 3, 12'h678), 4, 32'h12345678, 1'b0);
        add_entry(encode_op_imm(3'b100, 5, 4, 12'hFFF), 5, 32'hEDCBA987, 1'b0);
        add_entry(encode_op_imm(3'b111, 6, 4, 12'h0F0), 6, 32'h00000070, 1'b0);
        // SLTI and SLTIU with a negative source
        add_entry(encode_op_imm(3'b010, 7, 2, 12'hFFE), 7, 32'h00000001, 1'b0);
        add_entry(encode_op_imm(3'b011, 8, 2, 12'h005), 8, 32'h00000000, 1'b0);
        // SLLI, SRLI, SRAI
        add_entry(encode_op_imm(3'b001, 9, 1, 12'h004), 9, 32'h00000050, 1'b0);
        add_entry(encode_op_imm(3'b101, 10, 2, 12'h01C), 10, 32'h0000000F, 1'b0);
        add_entry(encode_op_imm(3'b101, 11, 2, 12'h401), 11, 32'hFFFFFFFE, 1'b0);
        // Register-register ops, SUB and SRA go negative
        add_entry(encode_op(7'h00, 3'b000, 12, 1, 2), 12, 32'h00000002, 1'b0);
        add_entry(encode_op(7'h20, 3'b000, 13, 2, 1), 13, 32'hFFFFFFF8, 1'b0);
        add_entry(encode_op(7'h20, 3'b101, 14, 13, 1), 14, 32'hFFFFFFFF, 1'b0);
        add_entry(encode_op(7'h00, 3'b010, 15, 13, 1), 15, 32'h00000001, 1'b0);
        add_entry(encode_op(7'h00, 3'b011, 16, 1, 13), 16, 32'h00000001, 1'b0);
        add_entry(encode_op(7'h00, 3'b100, 17, 4, 5), 17, 32'hFFFFFFFF, 1'b0);
        add_entry(encode_op(7'h00, 3'b001, 18, 1, 12), 18, 32'h00000014, 1'b0);
        add_entry(encode_op(7'h00, 3'b101, 19, 5, 1), 19, 32'h076E5D4C, 1'b0);
        add_entry(encode_op(7'h00, 3'b110, 20, 6, 9), 20, 32'h00000070, 1'b0);
        add_entry(encode_op(7'h00, 3'b111, 21, 4, 5), 21, 32'h00000000, 1'b0);
        // Dependent chain through x22, each one waits on the last
        add_entry(encode_op_imm(3'b000, 22, 1, 12'h001), 22, 32'h00000006, 1'b0);
        add_entry(encode_op_imm(3'b000, 22, 22, 12'h001), 22, 32'h00000007, 1'b0);
        add_entry(encode_op_imm(3'b001, 22, 22, 12'h002), 22, 32'h0000001C, 1'b0);
        add_entry(encode_op(7'h20, 3'b000, 23, 22, 1), 23, 32'h00000017, 1'b0);
        // x0 write retires its value but x0 stays zero
        add_entry(encode_op_imm(3'b000, 0, 1, 12'h007), 0, 32'h0000000C, 1'b0);
        add_entry(encode_op(7'h00, 3'b000, 24, 0, 1), 24, 32'h00000005, 1'b0);
        // Opcode 7F with x1 in the rd and both source fields, then x1 still holds 5
        add_entry(32'h001080FF, 1, 32'h00000000, 1'b1);
        add_entry(encode_op_imm(3'b000, 25, 1, 12'h000), 25, 32'h00000005, 1'b0);
        add_entry(encode_lui(26, 20'hFFFFF), 26, 32'hFFFFF000, 1'b0);
        add_entry(encode_op_imm(3'b101, 27, 26, 12'h40C), 27, 32'hFFFFFFFF, 1'b0);
        add_entry(encode_op(7'h20, 3'b000, 28, 0, 26), 28, 32'h00001000, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Four-phase memory, addresses past the table never get an ack
    initial begin : imem_model
        int delay;
        int index;
        forever begin
            @(negedge clk);
            if (imem_req === 1'b1) begin
                index = imem_addr >> 2;
                if (index < prog_len) begin
                    take_random_bits(2, delay);
                    repeat (delay) @(negedge clk);
                    imem_data = program_table[index].instruction;
                    imem_ack = 1'b1;
                    @(negedge clk);
                    while (imem_req === 1'b1) @(negedge clk);
                    take_random_bits(2, delay);
                    repeat (delay) @(negedge clk);
                    imem_ack = 1'b0;
                end
            end
        end
    end

    // Worst case per entry is well under 12 cycles
    initial begin : watchdog
        repeat (prog_len * 12 + 40) @(posedge clk);
        error_count++;
        $display("Retirement stalled, the time limit ran out before the program finished");
        report_counts(retired, prog_len);
        $display("Checks failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        imem_ack = 1'b0;
        imem_data = '0;
        build_program();
        repeat (5) @(negedge clk);
        reset = 1'b0;

        // Each retire compared with the next table entry, in order
        while (retired < prog_len) begin
            @(negedge clk);
            if (retire_valid) begin
                check_retire(retire, program_table[retired].expected, retired);
                retired++;
            end
        end

        // Nothing more may retire
        repeat (20) begin
            @(negedge clk);
            if (retire_valid) begin
                retired++;
            end
        end
        check_count(retired, prog_len);

        report_counts(retired, prog_len);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
